// File: rtl/fma_pkg.sv
// fp16 fma shared definitions
package fma_pkg;

    localparam int FRAC_W       = 10;  // stored fraction
    localparam int EXP_W        = 5;   // stored exponent
    localparam int MAN_W        = 11;  // fraction plus hidden bit
    localparam int BIAS         = 15;
    localparam int PROD_W       = 22;  // 11x11 mantissa product
    localparam int SUM_W        = 35;  // alignment and sum window
    localparam int C_BASE       = 10;  // lsb of c in the window before shifting
    localparam int MAX_LSHIFT   = 13;  // beyond this c is returned as is
    localparam int EXP_I_W      = 7;   // signed internal exponent
    localparam int LZ_W         = 6;
    localparam int BOOTH_GROUPS = 4;   // radix-8 digits of the multiplier

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp16_t;

    typedef logic [MAN_W-1:0]          man_t;
    typedef logic [PROD_W-1:0]         prod_t;
    typedef logic [SUM_W-1:0]          sum_t;
    typedef logic signed [EXP_I_W-1:0] exp_i_t;

    // sign-magnitude digit code, msb set for negative multiples
    typedef enum logic [3:0] {
        DIG_ZERO = 4'b0000,
        DIG_P1   = 4'b0001,
        DIG_P2   = 4'b0010,
        DIG_P3   = 4'b0011,
        DIG_P4   = 4'b0100,
        DIG_M1   = 4'b1001,
        DIG_M2   = 4'b1010,
        DIG_M3   = 4'b1011,
        DIG_M4   = 4'b1100
    } booth_digit_e;

endpackage

// File: rtl/fp16_unpack.sv
// fp16 operand unpack stage
`timescale 1ns/10ps

module fp16_unpack (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  fma_pkg::fp16_t  a,
    input  fma_pkg::fp16_t  b,
    input  fma_pkg::fp16_t  c,
    output logic            s1_valid,
    output logic            sign_ab,
    output logic            sign_c,
    output fma_pkg::exp_i_t exp_ab,
    output fma_pkg::exp_i_t exp_c,
    output fma_pkg::man_t   man_a,
    output fma_pkg::man_t   man_b,
    output fma_pkg::man_t   man_c
);

    // zero field still decodes as 1-bias
    function automatic fma_pkg::exp_i_t unbias(input logic [fma_pkg::EXP_W-1:0] field);
        if (field == '0) begin
            return fma_pkg::exp_i_t'(1 - fma_pkg::BIAS);
        end
        return fma_pkg::exp_i_t'(field) - fma_pkg::exp_i_t'(fma_pkg::BIAS);
    endfunction

    // no subnormals, a zero exponent field means the value is zero
    function automatic fma_pkg::man_t hidden(input fma_pkg::fp16_t x);
        return (x.exp != '0) ? {1'b1, x.frac} : '0;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            sign_ab  <= 1'b0;
            sign_c   <= 1'b0;
            exp_ab   <= '0;
            exp_c    <= '0;
            man_a    <= '0;
            man_b    <= '0;
            man_c    <= '0;
        end else begin
            s1_valid <= in_valid;
            sign_ab  <= a.sign ^ b.sign;
            sign_c   <= c.sign;
            exp_ab   <= unbias(a.exp) + unbias(b.exp);  // one exponent for a*b
            exp_c    <= unbias(c.exp);
            man_a    <= hidden(a);
            man_b    <= hidden(b);
            man_c    <= hidden(c);
        end
    end

endmodule

// File: rtl/booth_mult.sv
// radix-8 booth mantissa multiplier
`timescale 1ns/10ps

module booth_mult (
    input  fma_pkg::man_t  man_a,
    input  fma_pkg::man_t  man_b,
    output fma_pkg::prod_t prod
);

    fma_pkg::prod_t mul_p1;
    fma_pkg::prod_t mul_p2;
    fma_pkg::prod_t mul_p3;
    fma_pkg::prod_t mul_p4;
    fma_pkg::prod_t pp [fma_pkg::BOOTH_GROUPS];
    fma_pkg::prod_t sum1;
    fma_pkg::prod_t carry1;
    fma_pkg::prod_t sum2;
    fma_pkg::prod_t carry2;
    logic [3*fma_pkg::BOOTH_GROUPS:0] b_ext;

    function automatic fma_pkg::booth_digit_e recode(input logic [3:0] win);
        case (win)
            4'b0001, 4'b0010: return fma_pkg::DIG_P1;
            4'b0011, 4'b0100: return fma_pkg::DIG_P2;
            4'b0101, 4'b0110: return fma_pkg::DIG_P3;
            4'b0111:          return fma_pkg::DIG_P4;
            4'b1000:          return fma_pkg::DIG_M4;
            4'b1001, 4'b1010: return fma_pkg::DIG_M3;
            4'b1011, 4'b1100: return fma_pkg::DIG_M2;
            4'b1101, 4'b1110: return fma_pkg::DIG_M1;
            default:          return fma_pkg::DIG_ZERO;  // 0000 and 1111
        endcase
    endfunction

    function automatic fma_pkg::prod_t csa_sum(input fma_pkg::prod_t x, y, z);
        return x ^ y ^ z;
    endfunction

    function automatic fma_pkg::prod_t csa_carry(input fma_pkg::prod_t x, y, z);
        return ((x & y) | (y & z) | (x & z)) << 1;
    endfunction

    // multiples of a, held at product width so negatives wrap mod 2^22
    assign mul_p1 = fma_pkg::prod_t'(man_a);
    assign mul_p2 = mul_p1 << 1;
    assign mul_p4 = mul_p1 << 2;
    assign mul_p3 = mul_p1 + mul_p2;  // the one hard multiple

    // unsigned multiplier gets a zero above its msb, plus the implied 0 below bit 0
    assign b_ext = {{(3*fma_pkg::BOOTH_GROUPS-fma_pkg::MAN_W){1'b0}}, man_b, 1'b0};

    always_comb begin
        fma_pkg::booth_digit_e dig;
        fma_pkg::prod_t        sel;
        for (int g = 0; g < fma_pkg::BOOTH_GROUPS; g++) begin
            dig = recode(b_ext[3*g +: 4]);  // windows overlap by one bit
            case (dig)
                fma_pkg::DIG_P1: sel = mul_p1;
                fma_pkg::DIG_P2: sel = mul_p2;
                fma_pkg::DIG_P3: sel = mul_p3;
                fma_pkg::DIG_P4: sel = mul_p4;
                fma_pkg::DIG_M1: sel = -mul_p1;
                fma_pkg::DIG_M2: sel = -mul_p2;
                fma_pkg::DIG_M3: sel = -mul_p3;
                fma_pkg::DIG_M4: sel = -mul_p4;
                default:         sel = '0;
            endcase
            pp[g] = sel << (3*g);
        end
    end

    // two 3:2 layers, then the carry-propagate add
    assign sum1   = csa_sum(pp[0], pp[1], pp[2]);
    assign carry1 = csa_carry(pp[0], pp[1], pp[2]);
    assign sum2   = csa_sum(sum1, carry1, pp[3]);
    assign carry2 = csa_carry(sum1, carry1, pp[3]);
    assign prod   = sum2 + carry2;

endmodule

// File: rtl/align_add.sv
// addend alignment and signed add stage
`timescale 1ns/10ps

module align_add (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            s1_valid,
    input  logic            sign_ab,
    input  logic            sign_c,
    input  fma_pkg::exp_i_t exp_ab,
    input  fma_pkg::exp_i_t exp_c,
    input  fma_pkg::man_t   man_c,
    input  fma_pkg::prod_t  prod,
    output logic            s2_valid,
    output logic            res_sign,
    output fma_pkg::sum_t   sum_mag,
    output fma_pkg::exp_i_t exp_ab_q,
    output logic            c_dominant,
    output fma_pkg::fp16_t  c_bypass
);

    fma_pkg::exp_i_t             d;
    fma_pkg::exp_i_t             exp_c_biased;
    logic [fma_pkg::EXP_I_W-1:0] shamt;
    fma_pkg::sum_t               c_ext;
    fma_pkg::sum_t               c_aligned;
    fma_pkg::sum_t               addend;
    fma_pkg::sum_t               raw_sum;
    fma_pkg::sum_t               mag;
    fma_pkg::fp16_t              c_pack;
    logic                        eff_sub;
    logic                        neg;

    assign d     = exp_c - exp_ab;
    assign shamt = d[fma_pkg::EXP_I_W-1] ? -d : d;  // |d|

    // c sits at C_BASE, bits shifted below bit 0 are dropped
    assign c_ext     = fma_pkg::sum_t'(man_c) << fma_pkg::C_BASE;
    assign c_aligned = d[fma_pkg::EXP_I_W-1] ? (c_ext >> shamt) : (c_ext << shamt);

    assign eff_sub = sign_c ^ sign_ab;
    assign addend  = eff_sub ? ~c_aligned : c_aligned;
    assign raw_sum = fma_pkg::sum_t'(prod) + addend + fma_pkg::sum_t'(eff_sub);

    // a plain add may carry into the msb, only a subtract can go negative
    assign neg = eff_sub & raw_sum[fma_pkg::SUM_W-1];
    assign mag = neg ? -raw_sum : raw_sum;

    assign exp_c_biased = exp_c + fma_pkg::exp_i_t'(fma_pkg::BIAS);
    assign c_pack = {sign_c,
                     man_c[fma_pkg::MAN_W-1] ? exp_c_biased[fma_pkg::EXP_W-1:0]
                                             : {fma_pkg::EXP_W{1'b0}},
                     man_c[fma_pkg::FRAC_W-1:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid   <= 1'b0;
            res_sign   <= 1'b0;
            sum_mag    <= '0;
            exp_ab_q   <= '0;
            c_dominant <= 1'b0;
            c_bypass   <= '0;
        end else begin
            s2_valid   <= s1_valid;
            res_sign   <= sign_ab ^ neg;
            sum_mag    <= mag;
            exp_ab_q   <= exp_ab;
            c_dominant <= d > fma_pkg::exp_i_t'(fma_pkg::MAX_LSHIFT);
            c_bypass   <= c_pack;
        end
    end

endmodule

// File: rtl/lz_normalize.sv
// leading one normalize
`timescale 1ns/10ps

module lz_normalize (
    input  fma_pkg::sum_t   sum_mag,
    input  fma_pkg::exp_i_t exp_ab_q,
    output fma_pkg::man_t   norm_man,
    output logic            guard,
    output logic            round_bit,
    output logic            sticky,
    output logic            is_zero,
    output fma_pkg::exp_i_t norm_exp
);

    typedef logic [fma_pkg::LZ_W-1:0] lz_t;

    lz_t           lz;
    fma_pkg::sum_t shifted;

    always_comb begin
        lz = '0;
        for (int i = 0; i < fma_pkg::SUM_W; i++) begin
            if (sum_mag[i]) begin
                lz = lz_t'(fma_pkg::SUM_W - 1 - i);  // highest set bit wins
            end
        end
    end

    assign shifted = sum_mag << lz;  // leading one to the top

    assign norm_man  = shifted[fma_pkg::SUM_W-1 -: fma_pkg::MAN_W];
    assign guard     = shifted[fma_pkg::SUM_W-1-fma_pkg::MAN_W];
    assign round_bit = shifted[fma_pkg::SUM_W-2-fma_pkg::MAN_W];
    assign sticky    = |shifted[fma_pkg::SUM_W-3-fma_pkg::MAN_W:0];
    assign is_zero   = (sum_mag == '0);

    // window bit k weighs 2^(exp_ab-20+k), with k = 34-lz
    assign norm_exp = exp_ab_q
                    + fma_pkg::exp_i_t'(fma_pkg::SUM_W - 1 - 2*fma_pkg::FRAC_W)
                    - fma_pkg::exp_i_t'(lz);

endmodule

// File: rtl/round_pack.sv
// rounding and output pack stage
`timescale 1ns/10ps

module round_pack (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            s2_valid,
    input  logic            res_sign,
    input  logic            c_dominant,
    input  logic            is_zero,
    input  fma_pkg::fp16_t  c_bypass,
    input  fma_pkg::man_t   norm_man,
    input  logic            guard,
    input  logic            round_bit,
    input  logic            sticky,
    input  fma_pkg::exp_i_t norm_exp,
    output logic            out_valid,
    output fma_pkg::fp16_t  result
);

    logic                      inc;
    logic [fma_pkg::MAN_W:0]   man_r;
    fma_pkg::exp_i_t           exp_r;
    fma_pkg::fp16_t            res_d;

    // nearest even
    assign inc   = guard & (round_bit | sticky | norm_man[0]);
    assign man_r = {1'b0, norm_man} + {{fma_pkg::MAN_W{1'b0}}, inc};
    // a carry out leaves the fraction at zero, only the exponent moves
    assign exp_r = norm_exp + fma_pkg::exp_i_t'(fma_pkg::BIAS)
                 + fma_pkg::exp_i_t'(man_r[fma_pkg::MAN_W]);

    always_comb begin
        res_d = '0;  // +0 for an exact zero sum
        if (c_dominant) begin
            res_d = c_bypass;
        end else if (!is_zero) begin
            res_d.sign = res_sign;
            if (exp_r < fma_pkg::exp_i_t'(1)) begin
                res_d.exp  = '0;  // flush to signed zero
                res_d.frac = '0;
            end else if (exp_r > fma_pkg::exp_i_t'(2**fma_pkg::EXP_W - 2)) begin
                res_d.exp  = '1;  // signed infinity
                res_d.frac = '0;
            end else begin
                res_d.exp  = exp_r[fma_pkg::EXP_W-1:0];
                res_d.frac = man_r[fma_pkg::FRAC_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= s2_valid;
            result    <= res_d;
        end
    end

endmodule

// File: rtl/fma_fp16.sv
// pipelined fp16 fused multiply-add
`timescale 1ns/10ps

module fma_fp16 (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  fma_pkg::fp16_t a,
    input  fma_pkg::fp16_t b,
    input  fma_pkg::fp16_t c,
    output logic           out_valid,
    output fma_pkg::fp16_t result
);

    // stage 1
    logic            s1_valid;
    logic            sign_ab;
    logic            sign_c;
    fma_pkg::exp_i_t exp_ab;
    fma_pkg::exp_i_t exp_c;
    fma_pkg::man_t   man_a;
    fma_pkg::man_t   man_b;
    fma_pkg::man_t   man_c;
    fma_pkg::prod_t  prod;

    // stage 2
    logic            s2_valid;
    logic            res_sign;
    fma_pkg::sum_t   sum_mag;
    fma_pkg::exp_i_t exp_ab_q;
    logic            c_dominant;
    fma_pkg::fp16_t  c_bypass;

    // normalize outputs
    fma_pkg::man_t   norm_man;
    logic            guard;
    logic            round_bit;
    logic            sticky;
    logic            is_zero;
    fma_pkg::exp_i_t norm_exp;

    fp16_unpack u_unpack (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .c        (c),
        .s1_valid (s1_valid),
        .sign_ab  (sign_ab),
        .sign_c   (sign_c),
        .exp_ab   (exp_ab),
        .exp_c    (exp_c),
        .man_a    (man_a),
        .man_b    (man_b),
        .man_c    (man_c)
    );

    booth_mult u_mult (
        .man_a (man_a),
        .man_b (man_b),
        .prod  (prod)
    );

    align_add u_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .s1_valid   (s1_valid),
        .sign_ab    (sign_ab),
        .sign_c     (sign_c),
        .exp_ab     (exp_ab),
        .exp_c      (exp_c),
        .man_c      (man_c),
        .prod       (prod),
        .s2_valid   (s2_valid),
        .res_sign   (res_sign),
        .sum_mag    (sum_mag),
        .exp_ab_q   (exp_ab_q),
        .c_dominant (c_dominant),
        .c_bypass   (c_bypass)
    );

    lz_normalize u_norm (
        .sum_mag   (sum_mag),
        .exp_ab_q  (exp_ab_q),
        .norm_man  (norm_man),
        .guard     (guard),
        .round_bit (round_bit),
        .sticky    (sticky),
        .is_zero   (is_zero),
        .norm_exp  (norm_exp)
    );

    round_pack u_round (
        .clk        (clk),
        .rst_n      (rst_n),
        .s2_valid   (s2_valid),
        .res_sign   (res_sign),
        .c_dominant (c_dominant),
        .is_zero    (is_zero),
        .c_bypass   (c_bypass),
        .norm_man   (norm_man),
        .guard      (guard),
        .round_bit  (round_bit),
        .sticky     (sticky),
        .norm_exp   (norm_exp),
        .out_valid  (out_valid),
        .result     (result)
    );

endmodule

// File: test/fma_model.svh
// fp16 fma reference model
`ifndef FMA_MODEL_SVH
`define FMA_MODEL_SVH

// zero exponent field reads as 1-bias with no hidden bit
function automatic int model_exp(input fma_pkg::fp16_t x);
    if (x.exp == 5'd0) begin
        return -14;
    end
    return int'(x.exp) - 15;
endfunction

function automatic longint model_man(input fma_pkg::fp16_t x);
    if (x.exp == 5'd0) begin
        return 0;
    end
    return longint'({1'b1, x.frac});
endfunction

// a*b+c with c placed at bit 10 of the window, truncation below bit 0
function automatic fma_pkg::fp16_t fma_ref(input fma_pkg::fp16_t a, b, c);
    int          e_ab;
    int          d;
    int          k;
    int          e;
    longint      prod;
    longint      c_al;
    longint      sum;
    logic        sign;
    logic        inc;
    logic [63:0] top;
    logic [11:0] man;
    e_ab = model_exp(a) + model_exp(b);
    d    = model_exp(c) - e_ab;
    if (d > 13) begin
        if (c.exp == 5'd0) begin
            return {c.sign, 15'd0};
        end
        return c;
    end
    prod = model_man(a) * model_man(b);
    if (d >= 0) begin
        c_al = model_man(c) << (10 + d);
    end else begin
        c_al = (model_man(c) << 10) >> (-d);
    end
    sign = a.sign ^ b.sign;
    sum  = (c.sign == sign) ? prod + c_al : prod - c_al;
    if (sum < 0) begin
        sum  = -sum;
        sign = ~sign;
    end
    if (sum == 0) begin
        return 16'h0000;
    end
    k = 0;
    for (int i = 0; i < 40; i++) begin
        if (sum[i]) begin
            k = i;
        end
    end
    top = sum;
    top = top << (63 - k);  // leading one at bit 63
    inc = top[52] & (top[51] | (|top[50:0]) | top[53]);
    man = {1'b0, top[63:53]} + {11'd0, inc};
    e   = e_ab - 20 + k + 15 + int'(man[11]);
    if (e < 1) begin
        return {sign, 15'd0};
    end
    if (e > 30) begin
        return {sign, 5'h1f, 10'd0};
    end
    return {sign, 5'(e), man[9:0]};
endfunction

`endif

// File: test/tb_fma_fp16.sv
// fp16 fma testbench
`timescale 1ns/10ps

module tb_fma_fp16;

    localparam int N_RANDOM   = 1200;
    localparam int N_DOMINANT = 200;
    localparam int N_CANCEL   = 300;
    localparam int N_ZERO     = 150;
    localparam int N_STREAM   = 200;
    // streaming costs about two cycles a vector plus reset and drains
    localparam int TIMEOUT_CYCLES =
        2 * (N_RANDOM + N_DOMINANT + N_CANCEL + N_ZERO + 2 * N_STREAM) + 1500;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    fma_pkg::fp16_t a;
    fma_pkg::fp16_t b;
    fma_pkg::fp16_t c;
    logic           out_valid;
    fma_pkg::fp16_t result;

    logic [31:0]    lcg_state = 32'ha325;
    int             cycles = 0;
    int             checks = 0;
    int             errors = 0;
    int             test_base = 0;
    string          test_name = "reset";
    fma_pkg::fp16_t exp_q[$];   // expected results in issue order
    int             due_q[$];   // cycle each result is due

    `include "fma_model.svh"

    fma_fp16 uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:8]) % n;
    endfunction

    function automatic fma_pkg::fp16_t make_fp(input int e);
        fma_pkg::fp16_t x;
        x.sign = (rand_below(2) == 1);
        x.exp  = 5'(e);
        x.frac = 10'(rand_below(1024));
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic drive(input fma_pkg::fp16_t va, vb, vc);
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= va;
        b        <= vb;
        c        <= vc;
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = errors;
    endtask

    // drain the pipe and print one line for the test
    task automatic end_test(input int n);
        int waited;
        waited = 0;
        idle();
        while (exp_q.size() != 0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("missing out_valid: %0d results of %s never arrived", exp_q.size(),
                     test_name);
            errors += exp_q.size();
            exp_q.delete();
            due_q.delete();
        end
        $display("%s: %0d vectors, %0d errors", test_name, n, errors - test_base);
    endtask

    // exponents chosen so c sits between 10 below and 13 above the product
    task automatic pick_random(output fma_pkg::fp16_t va, vb, vc);
        int ea;
        int eb;
        int ec;
        do begin
            ea = 1 + rand_below(30);
            eb = 1 + rand_below(30);
            ec = ea + eb - 15 + rand_below(24) - 10;
        end while (ec < 1 || ec > 30);
        va = make_fp(ea);
        vb = make_fp(eb);
        vc = make_fp(ec);
    endtask

    task automatic run_random(input int n, input logic gaps);
        fma_pkg::fp16_t va, vb, vc;
        for (int i = 0; i < n; i++) begin
            pick_random(va, vb, vc);
            if (gaps) begin
                repeat (rand_below(3)) idle();
            end
            drive(va, vb, vc);
        end
    endtask

    task automatic run_dominant(input int n);
        int ea;
        int eb;
        int ec;
        for (int i = 0; i < n; i++) begin
            ec = 1 + rand_below(30);
            ea = 1 + rand_below(ec);
            eb = 1 + rand_below(ec + 1 - ea);  // keeps d at 14 or more
            drive(make_fp(ea), make_fp(eb), make_fp(ec));
        end
    endtask

    task automatic run_cancel(input int n);
        fma_pkg::fp16_t va, vb, vc, p;
        int s;
        int ea;
        for (int i = 0; i < n; i++) begin
            if (i % 4 == 3) begin
                s  = 10 + rand_below(8);  // product near the bottom of the range
                ea = 1 + rand_below(s - 1);
                va = make_fp(ea);
                vb = make_fp(s - ea);
                vc = make_fp(1);
                vc.sign = ~(va.sign ^ vb.sign);
            end else begin
                va = make_fp(8 + rand_below(15));
                vb = make_fp(8 + rand_below(15));
                if (i % 8 == 0) begin
                    vb.frac = '0;  // exact product cancels to +0
                end
                p  = fma_ref(va, vb, '0);
                vc = p;
                vc.sign = ~p.sign;
                if (p.exp == 5'd0 || p.exp == 5'd31) begin
                    vc.exp = 5'd15;
                end
                if (i % 8 != 0) begin
                    vc.frac = p.frac + 10'(rand_below(5) - 2);  // near neighbour
                end
            end
            drive(va, vb, vc);
        end
    endtask

    task automatic run_zero(input int n);
        fma_pkg::fp16_t va, vb, vc;
        int sel;
        for (int i = 0; i < n; i++) begin
            va  = make_fp(1 + rand_below(30));
            vb  = make_fp(1 + rand_below(30));
            vc  = make_fp(1 + rand_below(30));
            sel = rand_below(3);
            if (i % 5 == 4) begin
                // bare product on an exact tie or rounding up into the exponent
                va      = make_fp(8 + rand_below(15));
                vb      = make_fp(8 + rand_below(15));
                va.frac = (i % 3 == 2) ? 10'h3fe : 10'h200;
                vb.frac = (i % 3 == 0) ? 10'h003 : 10'h001;
                sel     = 2;
            end
            case (sel)
                0:       va.exp = '0;
                1:       vb.exp = '0;
                default: vc.exp = '0;
            endcase
            drive(va, vb, vc);
        end
    endtask

    // scoreboard sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && in_valid) begin
            exp_q.push_back(fma_ref(a, b, c));
            due_q.push_back(cycles + 3);
        end
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected out_valid with nothing in flight in %s", test_name);
            end else begin
                check(test_name, exp_q.pop_front(), result);
                check({test_name, " latency"}, due_q.pop_front(), cycles);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        c        = '0;
        start_test("reset");
        repeat (10) begin
            @(negedge clk);
            check("reset", 0, out_valid);
            check("reset", 0, result);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check("reset", 0, out_valid);
            check("reset", 0, result);
        end
        end_test(0);
        start_test("random_fma");
        run_random(N_RANDOM, 1'b0);
        end_test(N_RANDOM);
        start_test("dominant_addend");
        run_dominant(N_DOMINANT);
        end_test(N_DOMINANT);
        start_test("cancellation");
        run_cancel(N_CANCEL);
        end_test(N_CANCEL);
        start_test("zero_operands");
        run_zero(N_ZERO);
        end_test(N_ZERO);
        start_test("streaming");
        run_random(N_STREAM, 1'b1);
        end_test(N_STREAM);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+test
rtl/fma_pkg.sv
rtl/fp16_unpack.sv
rtl/booth_mult.sv
rtl/align_add.sv
rtl/lz_normalize.sv
rtl/round_pack.sv
rtl/fma_fp16.sv
test/tb_fma_fp16.sv

// File: run.sh
#!/bin/sh
# build and run the fp16 fma testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_fma_fp16 \
    -Mdir obj_dir -o sim_fma

./obj_dir/sim_fma > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
